// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/inst_decode.sv
  - verilog/reg_file.sv
  - verilog/int_execute.sv
  - verilog/wb_result.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - testbench/rv_ref_model.sv
      - testbench/tb_rv_core.sv

// File: build.f
verilog/rv_pkg.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/int_execute.sv
verilog/wb_result.sv
verilog/rv_core.sv
testbench/rv_ref_model.sv
testbench/tb_rv_core.sv

// File: testbench/rv_ref_model.sv
package rv_ref_model;
   import rv_pkg::*;

   localparam int unsigned prog_len   = 200;
   localparam int unsigned data_words = 64;
   localparam int unsigned seed       = 66978;

   logic [31:0]     prog [prog_len];
   logic [xlen-1:0] data_init [data_words];
   logic [xlen-1:0] data_model [data_words];
   retire_t         expected [$];

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
   endfunction

   // Small register set so that dependencies are frequent
   function automatic logic [4:0] pick_reg();
      return 5'($urandom_range(0, 7));
   endfunction

   // Forward distance in instructions, never past the final self-jump
   function automatic int unsigned pick_skip(int unsigned from);
      int unsigned room;
      room = prog_len - 1 - from;
      return $urandom_range(1, (room < 6) ? room : 6);
   endfunction

   function automatic void build_program();
      int unsigned i;
      int unsigned kind;
      logic [2:0]  f3;
      logic [2:0]  br_f3 [6];
      logic [11:0] imm;
      logic [6:0]  f7;
      logic [4:0]  rd_r;
      logic [4:0]  rs1_r;
      logic [4:0]  rs2_r;
      logic        alt;
      logic [5:0]  word;
      void'($urandom(seed));
      br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      for (int w = 0; w < data_words; w++)
         data_init[w] = $urandom();
      // x1..x7 get defined values before any read
      for (i = 1; i < 8; i++)
         prog[i - 1] = {12'($urandom()), 5'd0, 3'b000, 5'(i), op_imm};
      i = 7;
      while (i < prog_len - 1)
      begin
         kind  = $urandom_range(0, 9);
         f3    = 3'($urandom());
         rd_r  = pick_reg();
         rs1_r = pick_reg();
         rs2_r = pick_reg();
         alt   = 1'($urandom());
         word  = 6'($urandom_range(0, data_words - 1));
         case (kind)
            0, 1:
            begin
               f7      = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
               prog[i] = {f7, rs2_r, rs1_r, f3, rd_r, op_reg};
            end
            2, 3:
            begin
               imm = 12'($urandom());
               if (f3 == 3'd1)
                  imm[11:5] = 7'h00;
               else if (f3 == 3'd5)
                  imm[11:5] = alt ? 7'h20 : 7'h00;
               prog[i] = {imm, rs1_r, f3, rd_r, op_imm};
            end
            4: prog[i] = {20'($urandom()), rd_r, alt ? op_auipc : op_lui};
            5: prog[i] = {4'd0, word, 2'b00, 5'd0, 3'b010, rd_r, op_load};
            6: prog[i] = enc_s({4'd0, word, 2'b00}, rs2_r, 5'd0);
            7: prog[i] = enc_b(13'(4 * pick_skip(i)), rs2_r, rs1_r, br_f3[$urandom_range(0, 5)]);
            8: prog[i] = enc_j(21'(4 * pick_skip(i)), rd_r);
            // Absolute JALR target, odd offsets check that bit 0 is dropped
            default: prog[i] = {12'(4 * (i + pick_skip(i)) + alt), 5'd0, 3'b000, rd_r, op_jalr};
         endcase
         i++;
      end
      prog[prog_len - 1] = enc_j(21'd0, 5'd0);
   endfunction

   function automatic logic [xlen-1:0] alu_ref(logic [2:0] f3, logic alt, logic [xlen-1:0] a,
                                                logic [xlen-1:0] b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(logic [2:0] f3, logic [xlen-1:0] a, logic [xlen-1:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         3'd7:    return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   // Sequential ISA execution, one expected retire record per instruction
   function automatic void run_model();
      logic [xlen-1:0] x [32];
      logic [xlen-1:0] pc;
      logic [xlen-1:0] next_pc;
      logic [xlen-1:0] v;
      logic [31:0]     inst;
      logic [xlen-1:0] i_imm;
      logic [xlen-1:0] s_imm;
      logic [xlen-1:0] b_imm;
      logic [xlen-1:0] j_imm;
      logic [4:0]      rd;
      logic            wr;
      int unsigned     steps;
      for (int r = 0; r < 32; r++)
         x[r] = '0;
      data_model = data_init;
      expected.delete();
      pc    = '0;
      steps = 0;
      while (steps < 4 * prog_len)
      begin
         inst    = prog[pc[9:2]];
         rd      = inst[11:7];
         i_imm   = {{20{inst[31]}}, inst[31:20]};
         s_imm   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         b_imm   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         j_imm   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         next_pc = pc + 4;
         wr      = 1'b1;
         v       = '0;
         case (inst[6:0])
            op_lui:   v = {inst[31:12], 12'b0};
            op_auipc: v = pc + {inst[31:12], 12'b0};
            op_jal:
            begin
               v       = pc + 4;
               next_pc = pc + j_imm;
            end
            op_jalr:
            begin
               v       = pc + 4;
               next_pc = (x[inst[19:15]] + i_imm) & ~32'd1;
            end
            op_branch:
            begin
               wr = 1'b0;
               if (branch_ref(inst[14:12], x[inst[19:15]], x[inst[24:20]]))
                  next_pc = pc + b_imm;
            end
            op_load:  v = data_model[(x[inst[19:15]] + i_imm) >> 2];
            op_store:
            begin
               wr = 1'b0;
               data_model[(x[inst[19:15]] + s_imm) >> 2] = x[inst[24:20]];
            end
            op_imm:
               v = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, x[inst[19:15]], i_imm);
            default:
               v = alu_ref(inst[14:12], inst[30], x[inst[19:15]], x[inst[24:20]]);
         endcase
         if (wr && rd != 5'd0)
         begin
            x[rd] = v;
            expected.push_back('{pc: pc, rd: rd, data: v, we: 1'b1});
         end
         else
         begin
            expected.push_back('{pc: pc, rd: 5'd0, data: '0, we: 1'b0});
         end
         if (next_pc == pc)
            break;
         pc = next_pc;
         steps++;
      end
   endfunction

endpackage

// File: testbench/tb_rv_core.sv
module tb_rv_core import rv_pkg::*, rv_ref_model::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] reset_addr = 32'h0;

   logic            clk;
   logic            rst;
   logic            stall;
   logic [xlen-1:0] imem_addr;
   logic            imem_en;
   logic [31:0]     imem_rdata;
   logic [xlen-1:0] dmem_addr;
   logic [xlen-1:0] dmem_wdata;
   logic [3:0]      dmem_we;
   logic            dmem_re;
   logic [xlen-1:0] dmem_rdata;
   logic            retire_valid;
   retire_t         retire;

   logic [31:0]     imem [256];
   logic [xlen-1:0] dmem [data_words];
   int unsigned     retired;
   logic            rst_seen;
   logic            fetch_seen;

   rv_core #(
      .reset_pc (reset_addr)
   ) u_dut (
      .clk          (clk),
      .rst          (rst),
      .stall        (stall),
      .imem_addr    (imem_addr),
      .imem_en      (imem_en),
      .imem_rdata   (imem_rdata),
      .dmem_addr    (dmem_addr),
      .dmem_wdata   (dmem_wdata),
      .dmem_we      (dmem_we),
      .dmem_re      (dmem_re),
      .dmem_rdata   (dmem_rdata),
      .retire_valid (retire_valid),
      .retire       (retire)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_retire(input retire_t got, input retire_t exp);
      if (got !== exp)
      begin
         report_failure($sformatf("[ERROR] t=%0d ns: retire %h/%0d/%h/%b, expected %h/%0d/%h/%b",
            $time, got.pc, got.rd, got.data, got.we, exp.pc, exp.rd, exp.data, exp.we));
      end
   endtask

   task automatic check_word(input int unsigned idx, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
      if (got !== exp)
      begin
         report_failure($sformatf("[ERROR] t=%0d ns: dmem word %0d is %h, expected %h",
            $time, idx, got, exp));
      end
   endtask

   // Both memories answer one cycle after an enabled access and hold otherwise
   always @(posedge clk)
   begin
      if (imem_en)
         imem_rdata <= imem[imem_addr[9:2]];
      if (dmem_re)
         dmem_rdata <= dmem[dmem_addr[7:2]];
      for (int b = 0; b < 4; b++)
      begin
         if (dmem_we[b])
            dmem[dmem_addr[7:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
      if (rst)
         rst_seen <= 1'b1;
   end

   // Outputs are settled at the falling edge
   always @(negedge clk)
   begin
      if (rst)
      begin
         if (rst_seen && (retire_valid !== 1'b0 || dmem_we !== 4'b0 || dmem_re !== 1'b0))
            report_failure($sformatf("[ERROR] t=%0d ns: retire or dmem access in reset", $time));
      end
      else if (stall && (retire_valid || imem_en || dmem_we != 4'b0 || dmem_re))
      begin
         report_failure($sformatf("[ERROR] t=%0d ns: activity while stalled", $time));
      end
      else if (!fetch_seen && imem_en && imem_addr !== reset_addr)
      begin
         report_failure($sformatf("[ERROR] t=%0d ns: first fetch at %h, expected %h",
            $time, imem_addr, reset_addr));
      end
      else if (retired == 0 && dmem_we != 4'b0)
      begin
         report_failure($sformatf("[ERROR] t=%0d ns: dmem write before first retire", $time));
      end
      else
      begin
         if (imem_en)
            fetch_seen = 1'b1;
         // Self-jump keeps retiring once the model has run out
         if (retire_valid && expected.size() != 0)
         begin
            check_retire(retire, expected.pop_front());
            retired++;
         end
      end
   end

   initial
   begin
      int unsigned cycles;
      int unsigned quiet;
      int unsigned last_retired;
      retired     = 0;
      rst_seen    = 1'b0;
      fetch_seen  = 1'b0;
      rst         = 1'b1;
      stall       = 1'b0;
      imem_rdata  = nop_inst;
      dmem_rdata  = '0;
      build_program();
      run_model();
      for (int a = 0; a < 256; a++)
         imem[a] = (a < prog_len) ? prog[a] : nop_inst;
      for (int w = 0; w < data_words; w++)
         dmem[w] = data_init[w];

      repeat (2) @(posedge clk);
      #1 rst = 1'b0;

      cycles       = 0;
      quiet        = 0;
      last_retired = 0;
      while (expected.size() != 0)
      begin
         @(posedge clk);
         #1;
         stall = ($urandom_range(0, 3) == 0);
         cycles++;
         if (retired != last_retired)
         begin
            quiet        = 0;
            last_retired = retired;
         end
         else
         begin
            quiet++;
         end
         if (quiet > 64)
            report_failure("Timeout: no instruction retired within 64 cycles");
         else if (cycles > 5000)
            report_failure("Timeout: program did not complete within 5000 cycles");
      end

      @(posedge clk);
      #1 stall = 1'b0;
      for (int w = 0; w < data_words; w++)
         check_word(w, dmem[w], data_model[w]);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: verilog/inst_decode.sv
module inst_decode import rv_pkg::*; (
   input  logic [31:0]     inst,
   output dec_ctrl_t       ctrl,
   output logic [4:0]      rs1,
   output logic [4:0]      rs2,
   output logic [4:0]      rd,
   output logic [xlen-1:0] imm
);

   logic [6:0] opcode;
   logic [2:0] f3;
   logic       alt;

   // Register and immediate ALU ops share the funct3 mapping
   function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub_sra);
      case (funct3)
         3'b000:  return sub_sra ? alu_sub : alu_add;
         3'b001:  return alu_sll;
         3'b010:  return alu_slt;
         3'b011:  return alu_sltu;
         3'b100:  return alu_xor;
         3'b101:  return sub_sra ? alu_sra : alu_srl;
         3'b110:  return alu_or;
         default: return alu_and;
      endcase
   endfunction

   assign opcode = inst[6:0];
   assign f3     = inst[14:12];
   assign rs1    = inst[19:15];
   assign rs2    = inst[24:20];
   assign rd     = inst[11:7];

   // Bit 30 is an immediate bit for ADDI, only a function bit for shifts
   assign alt = inst[30] & ((opcode == op_reg) | (f3 == 3'b101));

   always_comb
   begin
      ctrl        = '0;
      ctrl.alu_op = alu_add;
      ctrl.wb_sel = wb_alu;
      ctrl.funct3 = f3;
      imm         = '0;
      case (opcode)
         op_lui:
         begin
            ctrl.a_zero    = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = {inst[31:12], 12'b0};
         end
         op_auipc:
         begin
            ctrl.a_pc      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = {inst[31:12], 12'b0};
         end
         op_jal:
         begin
            ctrl.jal       = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = wb_link;
            imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         op_jalr:
         begin
            ctrl.jalr      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = wb_link;
            imm            = {{20{inst[31]}}, inst[31:20]};
         end
         op_branch:
         begin
            ctrl.branch = 1'b1;
            imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         end
         op_load:
         begin
            ctrl.load      = 1'b1;
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = wb_mem;
            imm            = {{20{inst[31]}}, inst[31:20]};
         end
         op_store:
         begin
            ctrl.store = 1'b1;
            ctrl.b_imm = 1'b1;
            imm        = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         end
         op_imm:
         begin
            ctrl.alu_op    = alu_decode(f3, alt);
            ctrl.b_imm     = 1'b1;
            ctrl.reg_write = 1'b1;
            imm            = {{20{inst[31]}}, inst[31:20]};
         end
         op_reg:
         begin
            ctrl.alu_op    = alu_decode(f3, alt);
            ctrl.reg_write = 1'b1;
         end
         // Anything else behaves as a nop
         default: ;
      endcase
   end

endmodule

// File: verilog/int_execute.sv
module int_execute import rv_pkg::*; (
   input  dec_ctrl_t       ctrl,
   input  logic [xlen-1:0] pc,
   input  logic [xlen-1:0] imm,
   input  logic [xlen-1:0] rs1_val,
   input  logic [xlen-1:0] rs2_val,
   input  logic [4:0]      rd,
   output ex_result_t      result,
   output logic            redirect,
   output logic [xlen-1:0] target,
   output logic [xlen-1:0] mem_addr,
   output logic [xlen-1:0] mem_wdata,
   output logic [3:0]      mem_we,
   output logic            mem_re
);

   logic [xlen-1:0] a;
   logic [xlen-1:0] b;
   logic [xlen-1:0] alu;
   logic [4:0]      shamt;
   logic            taken;

   assign a     = ctrl.a_pc ? pc : (ctrl.a_zero ? '0 : rs1_val);
   assign b     = ctrl.b_imm ? imm : rs2_val;
   assign shamt = b[4:0];

   always_comb
   begin
      case (ctrl.alu_op)
         alu_sub:  alu = a - b;
         alu_sll:  alu = a << shamt;
         alu_slt:  alu = {31'b0, $signed(a) < $signed(b)};
         alu_sltu: alu = {31'b0, a < b};
         alu_xor:  alu = a ^ b;
         alu_srl:  alu = a >> shamt;
         alu_sra:  alu = $unsigned($signed(a) >>> shamt);
         alu_or:   alu = a | b;
         alu_and:  alu = a & b;
         default:  alu = a + b;
      endcase
   end

   // Branch compare works on the register operands directly
   always_comb
   begin
      case (ctrl.funct3)
         3'b000:  taken = rs1_val == rs2_val;
         3'b001:  taken = rs1_val != rs2_val;
         3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
         3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
         3'b110:  taken = rs1_val < rs2_val;
         3'b111:  taken = rs1_val >= rs2_val;
         default: taken = 1'b0;
      endcase
   end

   assign redirect = (ctrl.branch & taken) | ctrl.jal | ctrl.jalr;
   assign target   = ctrl.jalr ? {alu[xlen-1:1], 1'b0} : pc + imm;

   assign mem_addr  = alu;
   assign mem_wdata = rs2_val;
   assign mem_we    = {4{ctrl.store}};
   assign mem_re    = ctrl.load;

   assign result.alu       = alu;
   assign result.link      = pc + 32'd4;
   assign result.rd        = rd;
   assign result.reg_write = ctrl.reg_write;
   assign result.wb_sel    = ctrl.wb_sel;
   assign result.pc        = pc;
   // Squash is applied by the core
   assign result.valid     = 1'b1;

endmodule

// File: verilog/reg_file.sv
module reg_file import rv_pkg::*; (
   input  logic            clk,
   input  logic            we,
   input  logic [4:0]      wa,
   input  logic [xlen-1:0] wd,
   input  logic [4:0]      ra1,
   input  logic [4:0]      ra2,
   output logic [xlen-1:0] rd1,
   output logic [xlen-1:0] rd2
);

   // x0 has no storage
   logic [xlen-1:0] regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
      begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// File: verilog/rv_core.sv
module rv_core import rv_pkg::*; #(
   parameter logic [31:0] reset_pc = 32'h0
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            stall,
   output logic [xlen-1:0] imem_addr,
   output logic            imem_en,
   input  logic [31:0]     imem_rdata,
   output logic [xlen-1:0] dmem_addr,
   output logic [xlen-1:0] dmem_wdata,
   output logic [3:0]      dmem_we,
   output logic            dmem_re,
   input  logic [xlen-1:0] dmem_rdata,
   output logic            retire_valid,
   output retire_t         retire
);

   logic [xlen-1:0] pc;
   logic [xlen-1:0] ex_pc;
   logic            ex_squash;
   logic [31:0]     ex_inst;
   dec_ctrl_t       ctrl;
   logic [4:0]      rs1;
   logic [4:0]      rs2;
   logic [4:0]      rd;
   logic [xlen-1:0] imm;
   logic [xlen-1:0] rd1;
   logic [xlen-1:0] rd2;
   logic [xlen-1:0] rs1_val;
   logic [xlen-1:0] rs2_val;
   ex_result_t      ex_res;
   logic            redirect;
   logic [xlen-1:0] target;
   logic [3:0]      mem_we;
   logic            mem_re;
   ex_result_t      wb_q;
   logic            wb_reg_we;
   logic [4:0]      wb_reg_wa;
   logic [xlen-1:0] wb_reg_wd;
   logic            wb_valid;

   // Fetch, PC and execute-slot registers
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc        <= reset_pc;
         ex_squash <= 1'b1;
      end
      else if (!stall)
      begin
         pc        <= redirect ? target : pc + 32'd4;
         ex_pc     <= pc;
         // Drop the one instruction fetched behind a redirect
         ex_squash <= redirect;
      end
   end

   assign imem_addr = pc;
   assign imem_en   = ~stall;
   assign ex_inst   = ex_squash ? nop_inst : imem_rdata;

   inst_decode u_decode (
      .inst (ex_inst),
      .ctrl (ctrl),
      .rs1  (rs1),
      .rs2  (rs2),
      .rd   (rd),
      .imm  (imm)
   );

   reg_file u_regs (
      .clk (clk),
      .we  (wb_reg_we & ~stall),
      .wa  (wb_reg_wa),
      .wd  (wb_reg_wd),
      .ra1 (rs1),
      .ra2 (rs2),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   // Writeback bypass, covers load data as well
   assign rs1_val = (wb_reg_we && wb_reg_wa == rs1) ? wb_reg_wd : rd1;
   assign rs2_val = (wb_reg_we && wb_reg_wa == rs2) ? wb_reg_wd : rd2;

   int_execute u_execute (
      .ctrl      (ctrl),
      .pc        (ex_pc),
      .imm       (imm),
      .rs1_val   (rs1_val),
      .rs2_val   (rs2_val),
      .rd        (rd),
      .result    (ex_res),
      .redirect  (redirect),
      .target    (target),
      .mem_addr  (dmem_addr),
      .mem_wdata (dmem_wdata),
      .mem_we    (mem_we),
      .mem_re    (mem_re)
   );

   assign dmem_we = mem_we & {4{~stall}};
   assign dmem_re = mem_re & ~stall;

   // Writeback register, payload has no reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wb_q.valid <= 1'b0;
      end
      else if (!stall)
      begin
         wb_q       <= ex_res;
         wb_q.valid <= ex_res.valid & ~ex_squash;
      end
   end

   wb_result u_wb (
      .ex           (wb_q),
      .mem_rdata    (dmem_rdata),
      .reg_we       (wb_reg_we),
      .reg_wa       (wb_reg_wa),
      .reg_wd       (wb_reg_wd),
      .retire_valid (wb_valid),
      .retire       (retire)
   );

   assign retire_valid = wb_valid & ~stall;

   mem_rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
      !((dmem_we != 4'b0) && dmem_re));

   // A squashed slot decodes as a nop and leaves memory and the PC alone
   squash_is_quiet: assert property (@(posedge clk) disable iff (rst)
      ex_squash |-> (!redirect && mem_we == 4'b0 && !mem_re));

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

   // Data and address width
   localparam int unsigned xlen = 32;

   // Major opcodes
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   // ADDI x0, x0, 0
   localparam logic [31:0] nop_inst = 32'h0000_0013;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_sll,
      alu_slt,
      alu_sltu,
      alu_xor,
      alu_srl,
      alu_sra,
      alu_or,
      alu_and
   } alu_op_e;

   typedef enum logic [1:0] {
      wb_alu,
      wb_mem,
      wb_link
   } wb_sel_e;

   typedef struct packed {
      alu_op_e    alu_op;
      logic       a_pc;      // operand a is the instruction PC
      logic       a_zero;    // operand a is zero, for LUI
      logic       b_imm;
      logic       branch;
      logic       jal;
      logic       jalr;
      logic [2:0] funct3;
      logic       load;
      logic       store;
      logic       reg_write;
      wb_sel_e    wb_sel;
   } dec_ctrl_t;

   // Execute to writeback
   typedef struct packed {
      logic [xlen-1:0] alu;
      logic [xlen-1:0] link;
      logic [4:0]      rd;
      logic            reg_write;
      wb_sel_e         wb_sel;
      logic [xlen-1:0] pc;
      logic            valid;
   } ex_result_t;

   // One retired instruction on the trace port
   typedef struct packed {
      logic [xlen-1:0] pc;
      logic [4:0]      rd;
      logic [xlen-1:0] data;
      logic            we;
   } retire_t;

endpackage

// File: verilog/wb_result.sv
module wb_result import rv_pkg::*; (
   input  ex_result_t      ex,
   input  logic [xlen-1:0] mem_rdata,
   output logic            reg_we,
   output logic [4:0]      reg_wa,
   output logic [xlen-1:0] reg_wd,
   output logic            retire_valid,
   output retire_t         retire
);

   logic [xlen-1:0] value;

   always_comb
   begin
      case (ex.wb_sel)
         wb_mem:  value = mem_rdata;
         wb_link: value = ex.link;
         default: value = ex.alu;
      endcase
   end

   // x0 targets and squashed slots never write
   assign reg_we = ex.valid & ex.reg_write & (ex.rd != 5'd0);
   assign reg_wa = ex.rd;
   assign reg_wd = value;

   assign retire_valid = ex.valid;

   // Non-writing instructions report rd and data as zero
   assign retire.pc   = ex.pc;
   assign retire.rd   = reg_we ? ex.rd : 5'd0;
   assign retire.data = reg_we ? value : '0;
   assign retire.we   = reg_we;

endmodule
